// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_frontend
RTL_TOP   ?= rv_frontend
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
rv_decode_pkg.sv
pipe_stage.sv
ifu.sv
idu.sv
rv_frontend.sv
tb_rv_frontend.sv

// File: idu.sv
// rv64im instruction decoder
`timescale 1ns/1ps
module idu (
    input  rv_decode_pkg::fetch_pkt_t fetch_pkt,
    output rv_decode_pkg::dec_pkt_t   dec_pkt
);
    import rv_decode_pkg::*;

    localparam logic [ilen-1:0] ebreak_word = 32'h0010_0073;

    logic [ilen-1:0] inst;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [5:0]      funct6;
    logic            sign;
    op_t             op;
    fmt_t            fmt_major; // what the major opcode implies
    fmt_t            fmt;
    logic [xlen-1:0] imm;

    assign inst   = fetch_pkt.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign funct6 = inst[31:26]; // rv64 shifts use bit 25 for shamt
    assign sign   = inst[31];

    always_comb begin
        case (opcode)
            7'b0110111, 7'b0010111: fmt_major = fmt_u;         // lui, auipc
            7'b1101111:             fmt_major = fmt_j;
            7'b1100011:             fmt_major = fmt_b;
            7'b0100011:             fmt_major = fmt_s;
            7'b1100111, 7'b0000011, 7'b0010011,
            7'b0011011, 7'b1110011: fmt_major = fmt_i;
            default:                fmt_major = fmt_r;         // op, op-32
        endcase
    end

    always_comb begin
        op = op_illegal;
        case (opcode)
            7'b0110111: op = op_lui;
            7'b0010111: op = op_auipc;
            7'b1101111: op = op_jal;
            7'b1100111: op = (funct3 == 3'b000) ? op_jalr : op_illegal;
            7'b1100011: begin
                case (funct3)
                    3'b000:  op = op_beq;
                    3'b001:  op = op_bne;
                    3'b100:  op = op_blt;
                    3'b101:  op = op_bge;
                    3'b110:  op = op_bltu;
                    3'b111:  op = op_bgeu;
                    default: op = op_illegal;
                endcase
            end
            7'b0000011: begin
                case (funct3)
                    3'b000:  op = op_lb;
                    3'b001:  op = op_lh;
                    3'b010:  op = op_lw;
                    3'b011:  op = op_ld;
                    3'b100:  op = op_lbu;
                    3'b101:  op = op_lhu;
                    3'b110:  op = op_lwu;
                    default: op = op_illegal;
                endcase
            end
            7'b0100011: begin
                case (funct3)
                    3'b000:  op = op_sb;
                    3'b001:  op = op_sh;
                    3'b010:  op = op_sw;
                    3'b011:  op = op_sd;
                    default: op = op_illegal;
                endcase
            end
            7'b0010011: begin
                case (funct3)
                    3'b000:  op = op_addi;
                    3'b010:  op = op_slti;
                    3'b011:  op = op_sltiu;
                    3'b100:  op = op_xori;
                    3'b110:  op = op_ori;
                    3'b111:  op = op_andi;
                    3'b001:  op = (funct6 == 6'b000000) ? op_slli : op_illegal;
                    3'b101: begin
                        if (funct6 == 6'b000000) op = op_srli;
                        else if (funct6 == 6'b010000) op = op_srai;
                    end
                    default: op = op_illegal;
                endcase
            end
            7'b0011011: begin // word immediates, 5-bit shamt
                casez ({funct7, funct3})
                    10'b???????_000: op = op_addiw;
                    10'b0000000_001: op = op_slliw;
                    10'b0000000_101: op = op_srliw;
                    10'b0100000_101: op = op_sraiw;
                    default:         op = op_illegal;
                endcase
            end
            7'b0110011: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = op_add;
                    10'b0100000_000: op = op_sub;
                    10'b0000000_001: op = op_sll;
                    10'b0000000_010: op = op_slt;
                    10'b0000000_011: op = op_sltu;
                    10'b0000000_100: op = op_xor;
                    10'b0000000_101: op = op_srl;
                    10'b0100000_101: op = op_sra;
                    10'b0000000_110: op = op_or;
                    10'b0000000_111: op = op_and;
                    10'b0000001_000: op = op_mul;
                    10'b0000001_001: op = op_mulh;
                    10'b0000001_010: op = op_mulhsu;
                    10'b0000001_011: op = op_mulhu;
                    10'b0000001_100: op = op_div;
                    10'b0000001_101: op = op_divu;
                    10'b0000001_110: op = op_rem;
                    10'b0000001_111: op = op_remu;
                    default:         op = op_illegal;
                endcase
            end
            7'b0111011: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = op_addw;
                    10'b0100000_000: op = op_subw;
                    10'b0000000_001: op = op_sllw;
                    10'b0000000_101: op = op_srlw;
                    10'b0100000_101: op = op_sraw;
                    10'b0000001_000: op = op_mulw;
                    10'b0000001_100: op = op_divw;
                    10'b0000001_101: op = op_divuw;
                    10'b0000001_110: op = op_remw;
                    10'b0000001_111: op = op_remuw;
                    default:         op = op_illegal;
                endcase
            end
            7'b1110011: op = (inst == ebreak_word) ? op_ebreak : op_illegal;
            default:    op = op_illegal;
        endcase
    end

    // an illegal word falls back to r so its immediate reads zero
    assign fmt = (op == op_illegal) ? fmt_r : fmt_major;

    always_comb begin
        case (fmt)
            fmt_i:   imm = {{(xlen-12){sign}}, inst[31:20]};
            fmt_s:   imm = {{(xlen-12){sign}}, inst[31:25], inst[11:7]};
            fmt_b:   imm = {{(xlen-13){sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            fmt_u:   imm = {{(xlen-32){sign}}, inst[31:12], 12'b0};
            fmt_j:   imm = {{(xlen-21){sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        dec_pkt.pc        = fetch_pkt.pc;
        dec_pkt.inst      = inst;
        dec_pkt.op        = op;
        dec_pkt.fmt       = fmt;
        dec_pkt.imm       = imm;
        dec_pkt.rd        = inst[11:7];
        dec_pkt.rs1       = inst[19:15];
        dec_pkt.rs2       = inst[24:20];
        dec_pkt.shamt     = inst[25:20];
        dec_pkt.is_ebreak = (inst == ebreak_word);
        dec_pkt.illegal   = (op == op_illegal);
    end

endmodule

// File: ifu.sv
// wishbone instruction fetch unit
`timescale 1ns/1ps
module ifu #(
    parameter logic [rv_decode_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    output rv_decode_pkg::wb_req_t    wb_req,
    input  rv_decode_pkg::wb_rsp_t    wb_rsp,
    output logic                      fetch_valid,
    input  logic                      fetch_ready,
    output rv_decode_pkg::fetch_pkt_t fetch_pkt
);
    import rv_decode_pkg::*;

    typedef enum logic [1:0] {
        st_idle, // only seen right after reset
        st_bus,  // read outstanding
        st_hold  // word latched, waiting for s_fetch
    } state_t;

    state_t          state;
    logic [xlen-1:0] pc;
    logic [ilen-1:0] inst_q;
    logic            bus_active;

    assign bus_active = (state == st_bus);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            pc    <= reset_pc;
        end else begin
            case (state)
                st_idle: begin
                    state <= st_bus;
                end
                st_bus: begin
                    if (wb_rsp.ack) begin
                        state <= st_hold; // cyc and stb drop here
                    end
                end
                st_hold: begin
                    if (fetch_ready) begin
                        state <= st_bus;
                        pc    <= pc + xlen'(4);
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // instruction word, captured on the ack edge
    always_ff @(posedge clk) begin
        if (bus_active && wb_rsp.ack) begin
            inst_q <= wb_rsp.dat;
        end
    end

    assign wb_req.cyc = bus_active;
    assign wb_req.stb = bus_active;
    assign wb_req.adr = pc; // steady until ack

    assign fetch_valid    = (state == st_hold);
    assign fetch_pkt.pc   = pc; // pc only moves after the packet is taken
    assign fetch_pkt.inst = inst_q;

endmodule

// File: pipe_stage.sv
// valid/ready register slice
`timescale 1ns/1ps
module pipe_stage #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    // take a new entry when empty or when the held one leaves this cycle
    assign in_ready = !valid_q || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid; // drops to 0 when drained with nothing behind
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

endmodule

// File: rv_decode_pkg.sv
// rv64im decode definitions
package rv_decode_pkg;

    localparam int xlen       = 64; // one data word
    localparam int ilen       = 32; // no compressed words
    localparam int reg_addr_w = 5;

    // numbering follows the older decoder tables, rv64 memory ops keep 41..43
    typedef enum logic [6:0] {
        op_illegal = 7'd0,
        op_lui     = 7'd1,  op_auipc  = 7'd2,  op_jal    = 7'd3,  op_jalr   = 7'd4,
        op_beq     = 7'd5,  op_bne    = 7'd6,  op_blt    = 7'd7,  op_bge    = 7'd8,
        op_bltu    = 7'd9,  op_bgeu   = 7'd10,
        op_lb      = 7'd11, op_lh     = 7'd12, op_lw     = 7'd13, op_lbu    = 7'd14,
        op_lhu     = 7'd15,
        op_sb      = 7'd16, op_sh     = 7'd17, op_sw     = 7'd18,
        op_addi    = 7'd19, op_slti   = 7'd20, op_sltiu  = 7'd21, op_xori   = 7'd22,
        op_ori     = 7'd23, op_andi   = 7'd24,
        op_slli    = 7'd25, op_srli   = 7'd26, op_srai   = 7'd27, // 6-bit shamt
        op_add     = 7'd28, op_sub    = 7'd29, op_sll    = 7'd30, op_slt    = 7'd31,
        op_sltu    = 7'd32, op_xor    = 7'd33, op_srl    = 7'd34, op_sra    = 7'd35,
        op_or      = 7'd36, op_and    = 7'd37,
        op_mul     = 7'd38, op_mulh   = 7'd39, op_mulhsu = 7'd40,
        op_lwu     = 7'd41, op_ld     = 7'd42, op_sd     = 7'd43,
        op_mulhu   = 7'd44, op_div    = 7'd45, op_divu   = 7'd46,
        op_addiw   = 7'd47, op_slliw  = 7'd48, op_srliw  = 7'd49, op_sraiw  = 7'd50,
        op_addw    = 7'd51, op_subw   = 7'd52, op_sllw   = 7'd53, op_srlw   = 7'd54,
        op_sraw    = 7'd55,
        op_rem     = 7'd56, op_remu   = 7'd57,
        op_mulw    = 7'd58, op_divw   = 7'd59, op_divuw  = 7'd60, op_remw   = 7'd61,
        op_remuw   = 7'd62,
        op_ebreak  = 7'd63
    } op_t;

    typedef enum logic [2:0] {
        fmt_r = 3'd0, // no immediate
        fmt_i = 3'd1,
        fmt_s = 3'd2,
        fmt_b = 3'd3,
        fmt_u = 3'd4,
        fmt_j = 3'd5
    } fmt_t;

    // wishbone classic, read only
    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic [xlen-1:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic            ack;
        logic [ilen-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [ilen-1:0] inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [ilen-1:0]       inst;
        op_t                   op;
        fmt_t                  fmt;
        logic [xlen-1:0]       imm;   // already sign-extended
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [5:0]            shamt;
        logic                  is_ebreak;
        logic                  illegal;
    } dec_pkt_t;

endpackage

// File: rv_frontend.sv
// rv64im fetch and decode front end
`timescale 1ns/1ps
module rv_frontend #(
    parameter logic [rv_decode_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output rv_decode_pkg::wb_req_t  wb_req,
    input  rv_decode_pkg::wb_rsp_t  wb_rsp,
    output logic                    out_valid,
    input  logic                    out_ready,
    output rv_decode_pkg::dec_pkt_t out_pkt
);
    import rv_decode_pkg::*;

    logic       fetch_valid;
    logic       fetch_ready;
    fetch_pkt_t fetch_pkt;
    logic       sf_valid;  // s_fetch output, also the decoder input
    logic       sf_ready;  // back-pressure from s_decode
    fetch_pkt_t sf_pkt;
    dec_pkt_t   dec_pkt;

    ifu #(
        .reset_pc (reset_pc)
    ) i_ifu (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_pkt   (fetch_pkt)
    );

    pipe_stage #(
        .payload_t (fetch_pkt_t)
    ) i_s_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_data   (fetch_pkt),
        .out_valid (sf_valid),
        .out_ready (sf_ready),
        .out_data  (sf_pkt)
    );

    idu i_idu (
        .fetch_pkt (sf_pkt),
        .dec_pkt   (dec_pkt)
    );

    pipe_stage #(
        .payload_t (dec_pkt_t)
    ) i_s_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (sf_valid),
        .in_ready  (sf_ready),
        .in_data   (dec_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_pkt)
    );

endmodule

// File: tb_rv_frontend.sv
// rv64im front end testbench
`timescale 1ns/1ps
module tb_rv_frontend;
    import rv_decode_pkg::*;

    localparam logic [63:0] reset_pc = 64'h8000_0000;
    localparam int mem_words = 512;
    localparam int n_check   = 450;
    localparam int n_fast    = 4; // no wait states, no stalls at start

    localparam op_t base_ops [8] = '{op_add, op_sll, op_slt, op_sltu,
                                     op_xor, op_srl, op_or, op_and};
    localparam op_t mul_ops [8]  = '{op_mul, op_mulh, op_mulhsu, op_mulhu,
                                     op_div, op_divu, op_rem, op_remu};

    logic     clk = 1'b0;
    logic     rst_n;
    wb_req_t  wb_req;
    wb_rsp_t  wb_rsp;
    logic     out_valid;
    logic     out_ready;
    dec_pkt_t out_pkt;

    logic [31:0] mem [0:mem_words-1];
    logic [31:0] lfsr = 32'h12f9b596;
    int          errors = 0;
    int          accepted = 0;
    int          cycle = 0;
    int          first_ack = -1;
    int          first_valid = -1;
    int          wait_cnt = 0;
    logic [63:0] exp_adr = reset_pc;
    logic [63:0] exp_pc = reset_pc;
    logic        held = 1'b0;
    dec_pkt_t    held_pkt;

    rv_frontend #(.reset_pc(reset_pc)) i_rv_frontend (
        .clk (clk), .rst_n (rst_n), .wb_req (wb_req), .wb_rsp (wb_rsp),
        .out_valid (out_valid), .out_ready (out_ready), .out_pkt (out_pkt)
    );

    always #4 clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] mem_word(logic [63:0] adr);
        logic [63:0] idx;
        idx = (adr - reset_pc) >> 2;
        if (idx < mem_words) return mem[idx[8:0]];
        return ~adr[31:0]; // outside the program
    endfunction

    function automatic op_t ref_op(logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            7'h37: return op_lui;
            7'h17: return op_auipc;
            7'h6f: return op_jal;
            7'h67: return (f3 == 3'd0) ? op_jalr : op_illegal;
            7'h63: begin
                if (f3 < 3'd2) return op_t'(7'd5 + 7'(f3));
                if (f3 > 3'd3) return op_t'(7'd3 + 7'(f3));
            end
            7'h03: begin
                if (f3 < 3'd3) return op_t'(7'd11 + 7'(f3));
                if (f3 == 3'd3) return op_ld;
                if (f3 < 3'd6) return op_t'(7'd10 + 7'(f3));
                if (f3 == 3'd6) return op_lwu;
            end
            7'h23: begin
                if (f3 < 3'd3) return op_t'(7'd16 + 7'(f3));
                if (f3 == 3'd3) return op_sd;
            end
            7'h13: begin
                if (f3 == 3'd0) return op_addi;
                if (f3 >= 3'd2 && f3 <= 3'd4) return op_t'(7'd18 + 7'(f3));
                if (f3 >= 3'd6) return op_t'(7'd17 + 7'(f3));
                if (f3 == 3'd1 && w[31:26] == 6'h00) return op_slli;
                if (f3 == 3'd5 && w[31:26] == 6'h00) return op_srli;
                if (f3 == 3'd5 && w[31:26] == 6'h10) return op_srai;
            end
            7'h1b: begin
                if (f3 == 3'd0) return op_addiw;
                if (f3 == 3'd1 && f7 == 7'h00) return op_slliw;
                if (f3 == 3'd5 && f7 == 7'h00) return op_srliw;
                if (f3 == 3'd5 && f7 == 7'h20) return op_sraiw;
            end
            7'h33: begin
                if (f7 == 7'h00) return base_ops[f3];
                if (f7 == 7'h01) return mul_ops[f3];
                if (f7 == 7'h20 && f3 == 3'd0) return op_sub;
                if (f7 == 7'h20 && f3 == 3'd5) return op_sra;
            end
            7'h3b: begin
                if (f7 == 7'h00 && f3 == 3'd0) return op_addw;
                if (f7 == 7'h00 && f3 == 3'd1) return op_sllw;
                if (f7 == 7'h00 && f3 == 3'd5) return op_srlw;
                if (f7 == 7'h20 && f3 == 3'd0) return op_subw;
                if (f7 == 7'h20 && f3 == 3'd5) return op_sraw;
                if (f7 == 7'h01 && f3 == 3'd0) return op_mulw;
                if (f7 == 7'h01 && f3 >= 3'd4) return op_t'(7'd55 + 7'(f3));
            end
            7'h73: return (w == 32'h0010_0073) ? op_ebreak : op_illegal;
            default: return op_illegal;
        endcase
        return op_illegal;
    endfunction

    function automatic dec_pkt_t ref_decode(logic [63:0] pc, logic [31:0] w);
        dec_pkt_t          p;
        logic signed [63:0] imm;
        p.pc    = pc;
        p.inst  = w;
        p.op    = ref_op(w);
        case (w[6:0])
            7'h37, 7'h17:                      p.fmt = fmt_u;
            7'h6f:                             p.fmt = fmt_j;
            7'h63:                             p.fmt = fmt_b;
            7'h23:                             p.fmt = fmt_s;
            7'h67, 7'h03, 7'h13, 7'h1b, 7'h73: p.fmt = fmt_i;
            default:                           p.fmt = fmt_r;
        endcase
        if (p.op == op_illegal) p.fmt = fmt_r;
        case (p.fmt)
            fmt_i:   imm = $signed(w[31:20]);
            fmt_s:   imm = $signed({w[31:25], w[11:7]});
            fmt_b:   imm = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
            fmt_u:   imm = $signed({w[31:12], 12'h000});
            fmt_j:   imm = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
            default: imm = 64'sd0;
        endcase
        p.imm       = imm;
        p.rd        = w[11:7];
        p.rs1       = w[19:15];
        p.rs2       = w[24:20];
        p.shamt     = w[25:20];
        p.is_ebreak = (w == 32'h0010_0073);
        p.illegal   = (p.op == op_illegal);
        return p;
    endfunction

    task automatic check_field(string name, logic [63:0] exp, logic [63:0] act);
        if (exp !== act) begin
            $display("mismatch %s at pc %h: expected %h actual %h", name, exp_pc, exp, act);
            errors++;
        end
    endtask

    // wishbone slave and out_ready, one process so the lfsr order is fixed
    always @(posedge clk) begin
        #1;
        if (!rst_n) begin
            wb_rsp    <= '0;
            out_ready <= 1'b1;
        end else begin
            if (wb_rsp.ack) begin
                wb_rsp.ack <= 1'b0;
                wait_cnt   = (accepted < n_fast) ? 0 : int'(take_bits(2));
            end else if (wb_req.cyc && wb_req.stb) begin
                if (wb_req.adr !== exp_adr) begin
                    $display("mismatch adr: expected %h actual %h", exp_adr, wb_req.adr);
                    errors++;
                end
                if (wait_cnt == 0) begin
                    wb_rsp.ack <= 1'b1;
                    wb_rsp.dat <= mem_word(wb_req.adr);
                    exp_adr    = exp_adr + 64'd4;
                end else begin
                    wait_cnt--;
                end
            end else if (wb_req.cyc != wb_req.stb) begin
                $display("cyc and stb differ on the fetch bus");
                errors++;
            end
            out_ready <= (accepted < n_fast) ? 1'b1 : (take_bits(2) != 0);
        end
    end

    // compare process, samples the values settled before each edge
    always @(posedge clk) begin
        dec_pkt_t e;
        if (rst_n) begin
            cycle++;
            if (wb_rsp.ack && first_ack < 0) first_ack = cycle;
            if (out_valid && first_valid < 0) begin
                first_valid = cycle;
                // high after the 2nd edge past ack, so seen on the 3rd
                if (first_valid - first_ack != 3) begin
                    $display("first out_valid came %0d cycles after ack, expected 2",
                             first_valid - first_ack - 1);
                    errors++;
                end
            end
            if (held && (!out_valid || out_pkt !== held_pkt)) begin
                $display("out_pkt changed while stalled at pc %h", held_pkt.pc);
                errors++;
            end
            held     = out_valid && !out_ready;
            held_pkt = out_pkt;
            if (out_valid && out_ready) begin
                e = ref_decode(exp_pc, mem_word(exp_pc));
                check_field("pc", e.pc, out_pkt.pc);
                check_field("inst", 64'(e.inst), 64'(out_pkt.inst));
                check_field("op", 64'(e.op), 64'(out_pkt.op));
                check_field("fmt", 64'(e.fmt), 64'(out_pkt.fmt));
                check_field("imm", e.imm, out_pkt.imm);
                check_field("rd", 64'(e.rd), 64'(out_pkt.rd));
                check_field("rs1", 64'(e.rs1), 64'(out_pkt.rs1));
                check_field("rs2", 64'(e.rs2), 64'(out_pkt.rs2));
                check_field("shamt", 64'(e.shamt), 64'(out_pkt.shamt));
                check_field("is_ebreak", 64'(e.is_ebreak), 64'(out_pkt.is_ebreak));
                check_field("illegal", 64'(e.illegal), 64'(out_pkt.illegal));
                exp_pc = exp_pc + 64'd4;
                accepted++;
            end
        end
    end

    initial begin
        logic [6:0]  opcs [12];
        logic [6:0]  f7s [4];
        int          n;
        int          t;
        opcs = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h03, 7'h23, 7'h13, 7'h1b,
                 7'h33, 7'h3b, 7'h73, 7'h7f};
        f7s  = '{7'h00, 7'h01, 7'h20, 7'h7f}; // 7f sets bit 31
        n = 0;
        foreach (opcs[o]) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                foreach (f7s[k]) begin
                    mem[n] = {f7s[k], 10'(take_bits(10)), 3'(f3), 5'(take_bits(5)), opcs[o]};
                    n++;
                end
            end
        end
        mem[n] = 32'h0010_0073; // ebreak
        n++;
        for (int i = n; i < mem_words; i++) mem[i] = take_bits(32);
        rst_n     = 1'b0;
        out_ready = 1'b1;
        wb_rsp    = '0;
        repeat (4) @(posedge clk);
        #1;
        if (wb_req.cyc || wb_req.stb || out_valid) begin
            $display("cyc, stb or out_valid high during reset");
            errors++;
        end
        @(posedge clk);
        #1 rst_n = 1'b1;
        t = 0;
        while (accepted < n_check && t < 40000) begin
            @(posedge clk);
            t++;
        end
        if (accepted < n_check) begin
            $display("timeout: only %0d of %0d packets came out", accepted, n_check);
            errors++;
        end
        $display("packets checked: %0d, errors: %0d", accepted, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
